//--- Bender.yml
package:
  name: sfifo

sources:
  # RTL, package first
  - files:
      - verilog/sfifo_pkg.sv
      - verilog/sfifo_ram.sv
      - verilog/sfifo_status.sv
      - verilog/sfifo_ctl.sv
      - verilog/sfifo_top.sv

  # Testbench
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_sfifo.sv

//--- all.f
verilog/sfifo_pkg.sv
verilog/sfifo_ram.sv
verilog/sfifo_status.sv
verilog/sfifo_ctl.sv
verilog/sfifo_top.sv
test/tb_clk_gen.sv
test/tb_sfifo.sv

//--- test/tb_clk_gen.sv
/* Testbench clock and reset source for the FIFO, 4 ns period.
   Reset is high from time zero and drops after four rising edges. */
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  // Half of the 4 ns period
  localparam int HALF_NS    = 2;
  localparam int RST_CYCLES = 4;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_NS) clk_o = ~clk_o;
  end

  // Release lines up with a rising edge
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

//--- test/tb_sfifo.sv
/* Top of the FIFO simulation. Runs directed fill, drain and error cases and
   random traffic, and checks the DUT every cycle against a queue model. */
`timescale 1ns/10ps

module tb_sfifo
  import sfifo_pkg::*;
;

  // Cycles any single wait may take
  localparam int WAIT_LIMIT    = 64;
  localparam int RANDOM_CYCLES = 400;

  logic         clk;
  logic         a_rst;
  logic         wr_en;
  logic         rd_en;
  sfifo_word_t  wr_data;
  logic         wr_ack;
  logic         rd_valid;
  sfifo_word_t  rd_data;
  sfifo_flags_t flags_o;
  sfifo_count_t count_o;
  sfifo_err_t   err_o;

  // Reference queue with the next word to read at the front
  sfifo_word_t model_q[$];

  // Strobes expected by the model and strobes seen on the DUT
  int ack_exp;
  int valid_exp;
  int ovf_exp;
  int unf_exp;
  int ack_seen;
  int valid_seen;
  int ovf_seen;
  int unf_seen;

  string cur_test;
  int    checks;
  int    errors;
  int    errors_at_start;
  int    tests_run;
  int    word_seq;
  bit    timed_out;

  tb_clk_gen u_clk_gen (
    .clk_o (clk),
    .rst_o (a_rst)
  );

  sfifo_top u_sfifo_top (
    .clk_i      (clk),
    .a_rst_i    (a_rst),
    .wr_en_i    (wr_en),
    .wr_data_i  (wr_data),
    .wr_ack_o   (wr_ack),
    .rd_en_i    (rd_en),
    .rd_valid_o (rd_valid),
    .rd_data_o  (rd_data),
    .flags_o    (flags_o),
    .count_o    (count_o),
    .err_o      (err_o)
  );

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------

  // Expected flags for an occupancy with prog flags held between thresholds
  function automatic sfifo_flags_t expect_flags(input int occ, input sfifo_flags_t prev);
    sfifo_flags_t f;
    f.empty        = (occ == 0);
    f.almost_empty = (occ <= 1);
    f.almost_full  = (occ >= FIFO_DEPTH - 1);
    f.full         = (occ == FIFO_DEPTH);
    if (occ >= PROG_FULL_ASSERT) f.prog_full = 1'b1;
    else if (occ <= PROG_FULL_NEGATE) f.prog_full = 1'b0;
    else f.prog_full = prev.prog_full;
    if (occ <= PROG_EMPTY_ASSERT) f.prog_empty = 1'b1;
    else if (occ >= PROG_EMPTY_NEGATE) f.prog_empty = 1'b0;
    else f.prog_empty = prev.prog_empty;
    return f;
  endfunction

  // Random data with a running tag so words stay distinct
  function automatic sfifo_word_t make_word();
    sfifo_word_t w;
    w.data = 24'($urandom);
    w.tag  = 8'(word_seq);
    word_seq++;
    return w;
  endfunction

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------

  task automatic check_word(input string item, input sfifo_word_t exp, input sfifo_word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s %s expected %h actual %h", cur_test, item, exp, act);
    end
  endtask

  task automatic check_flags(input string item, input sfifo_flags_t exp,
                             input sfifo_flags_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s %s expected %b actual %b", cur_test, item, exp, act);
    end
  endtask

  task automatic check_count(input string item, input sfifo_count_t exp,
                             input sfifo_count_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s %s expected %0d actual %0d", cur_test, item, exp, act);
    end
  endtask

  task automatic check_err(input string item, input sfifo_err_t exp, input sfifo_err_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s %s expected %b actual %b", cur_test, item, exp, act);
    end
  endtask

  // Single-bit handshake strobes
  task automatic check_strobe(input string item, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s %s expected %b actual %b", cur_test, item, exp, act);
    end
  endtask

  // --------------------------------------------------
  // Compare process
  // --------------------------------------------------

  // Model steps on the rising edge and DUT outputs are checked on the falling edge
  initial begin : compare_proc
    logic         wr_s;
    logic         rd_s;
    sfifo_word_t  d_s;
    logic         exp_ack;
    logic         exp_valid;
    sfifo_err_t   exp_err;
    sfifo_flags_t exp_flags;
    sfifo_word_t  last_word;
    logic         have_word;
    exp_flags = '0;
    last_word = '0;
    have_word = 1'b0;
    forever begin
      @(posedge clk);
      if (a_rst) begin
        model_q.delete();
        exp_ack   = 1'b0;
        exp_valid = 1'b0;
        exp_err   = '0;
        exp_flags = expect_flags(0, '0);
      end else begin
        // Inputs as the DUT sampled them on this edge
        wr_s = wr_en;
        rd_s = rd_en;
        d_s  = wr_data;
        exp_ack           = wr_s && (model_q.size() < FIFO_DEPTH);
        exp_valid         = rd_s && (model_q.size() > 0);
        exp_err.overflow  = wr_s && (model_q.size() == FIFO_DEPTH);
        exp_err.underflow = rd_s && (model_q.size() == 0);
        // Read takes the old front before the write lands
        if (exp_valid) last_word = model_q.pop_front();
        if (exp_ack) model_q.push_back(d_s);
        exp_flags = expect_flags(model_q.size(), exp_flags);
        ack_exp   += exp_ack;
        valid_exp += exp_valid;
        ovf_exp   += exp_err.overflow;
        unf_exp   += exp_err.underflow;
      end
      @(negedge clk);
      check_count("count_o", sfifo_count_t'(model_q.size()), count_o);
      check_flags("flags_o", exp_flags, flags_o);
      check_err("err_o", exp_err, err_o);
      check_strobe("wr_ack_o", exp_ack, wr_ack);
      check_strobe("rd_valid_o", exp_valid, rd_valid);
      if (exp_valid) have_word = 1'b1;
      // Read data also holds between reads
      if (have_word) check_word("rd_data_o", last_word, rd_data);
      ack_seen   += (wr_ack === 1'b1);
      valid_seen += (rd_valid === 1'b1);
      ovf_seen   += (err_o.overflow === 1'b1);
      unf_seen   += (err_o.underflow === 1'b1);
    end
  end

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------

  task automatic drive_cycle(input logic wr, input logic rd, input sfifo_word_t data);
    @(posedge clk);
    wr_en   <= wr;
    rd_en   <= rd;
    wr_data <= data;
  endtask

  // Marks the run as failed and names the wait that expired
  task automatic report_timeout(input string what);
    timed_out = 1'b1;
    $display("Timeout in test %s while waiting for %s", cur_test, what);
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (a_rst !== 1'b0 && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (a_rst !== 1'b0) report_timeout("reset release");
  endtask

  // Every strobe the model expects has shown up on the DUT
  task automatic wait_strobes_done();
    int n;
    logic done;
    n    = 0;
    done = 1'b0;
    while (!done && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
      done = (ack_seen >= ack_exp) && (valid_seen >= valid_exp) &&
             (ovf_seen >= ovf_exp) && (unf_seen >= unf_exp);
    end
    if (!done) report_timeout("ack, valid and error strobes");
  endtask

  // Reads until the empty flag shows
  // The read strobe still pending then meets an empty FIFO and underflows
  task automatic drain_fifo();
    int n;
    logic is_empty;
    n        = 0;
    is_empty = 1'b0;
    while (!is_empty && n < WAIT_LIMIT) begin
      drive_cycle(1'b0, 1'b1, '0);
      @(negedge clk);
      is_empty = flags_o.empty;
      n++;
    end
    if (!is_empty) report_timeout("the FIFO to drain");
  endtask

  task automatic begin_test(input string name);
    cur_test        = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    $display("Test %-10s %s (%0d errors)", cur_test,
             (errors == errors_at_start) ? "ok" : "failed", errors - errors_at_start);
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  // Stops at the first wait that expires
  task automatic run_tests();
    int   i;
    logic wr;
    logic rd;
    begin_test("reset");
    wait_reset_release();
    if (timed_out) return;
    wait_strobes_done();
    if (timed_out) return;
    end_test();

    // prog_full at 12 and full at 16 come from the model flags
    begin_test("fill");
    for (i = 0; i < FIFO_DEPTH; i++) drive_cycle(1'b1, 1'b0, make_word());
    drive_cycle(1'b0, 1'b0, '0);
    wait_strobes_done();
    if (timed_out) return;
    end_test();

    begin_test("overflow");
    drive_cycle(1'b1, 1'b0, make_word());
    drive_cycle(1'b0, 1'b0, '0);
    wait_strobes_done();
    if (timed_out) return;
    end_test();

    begin_test("drain");
    for (i = 0; i < FIFO_DEPTH; i++) drive_cycle(1'b0, 1'b1, '0);
    drive_cycle(1'b0, 1'b0, '0);
    wait_strobes_done();
    if (timed_out) return;
    end_test();

    begin_test("underflow");
    drive_cycle(1'b0, 1'b1, '0);
    drive_cycle(1'b0, 1'b0, '0);
    wait_strobes_done();
    if (timed_out) return;
    end_test();

    // Write-heavy and read-heavy phases swing the FIFO end to end
    begin_test("random");
    for (i = 0; i < RANDOM_CYCLES; i++) begin
      if ((i / 50) % 2 == 0) begin
        wr = (($urandom % 10) < 7);
        rd = (($urandom % 10) < 4);
      end else begin
        wr = (($urandom % 10) < 3);
        rd = (($urandom % 10) < 6);
      end
      drive_cycle(wr, rd, make_word());
    end
    drain_fifo();
    if (timed_out) return;
    drive_cycle(1'b0, 1'b0, '0);
    wait_strobes_done();
    if (timed_out) return;
    end_test();
  endtask

  initial begin : stimulus
    void'($urandom(32'h59f7));
    wr_en   = 1'b0;
    rd_en   = 1'b0;
    wr_data = '0;
    run_tests();
    $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- verilog/sfifo_ctl.sv
/* FIFO controller: qualifies write and read strobes against full and empty,
   steps the storage addresses and registers ack, valid and error strobes. */
`timescale 1ns/10ps

module sfifo_ctl
  import sfifo_pkg::*;
(
  input  logic         clk_i,
  input  logic         a_rst_i,
  input  logic         wr_en_i,
  input  logic         rd_en_i,
  input  sfifo_flags_t flags_i,
  output logic         wr_ram_o,
  output logic         rd_ram_o,
  output sfifo_addr_t  wr_adr_o,
  output sfifo_addr_t  rd_adr_o,
  output logic         wr_ack_o,
  output logic         rd_valid_o,
  output sfifo_err_t   err_o
);

  // Last storage address before the counters wrap
  localparam sfifo_addr_t MAX_ADR = sfifo_addr_t'(FIFO_DEPTH - 1);

  // --------------------------------------------------
  // Accept strobes
  // --------------------------------------------------

  // Write only into a FIFO that is not full
  assign wr_ram_o = wr_en_i & ~flags_i.full;

  // Read only from a FIFO that is not empty
  // Simultaneous write and read are each judged on their own flag
  assign rd_ram_o = rd_en_i & ~flags_i.empty;

  // --------------------------------------------------
  // Write address counter and acknowledge
  // --------------------------------------------------

  always_ff @(posedge clk_i or posedge a_rst_i) begin
    if (a_rst_i) begin
      wr_adr_o <= '0;
    end else if (wr_ram_o) begin
      // Wrap at the top of the array
      if (wr_adr_o == MAX_ADR) begin
        wr_adr_o <= '0;
      end else begin
        wr_adr_o <= wr_adr_o + 1'b1;
      end
    end
  end

  // Ack follows an accepted write by one cycle
  always_ff @(posedge clk_i or posedge a_rst_i) begin
    if (a_rst_i) begin
      wr_ack_o <= 1'b0;
    end else begin
      wr_ack_o <= wr_ram_o;
    end
  end

  // --------------------------------------------------
  // Read address counter and valid strobe
  // --------------------------------------------------

  always_ff @(posedge clk_i or posedge a_rst_i) begin
    if (a_rst_i) begin
      rd_adr_o <= '0;
    end else if (rd_ram_o) begin
      // Storage reads the old address on this edge
      if (rd_adr_o == MAX_ADR) begin
        rd_adr_o <= '0;
      end else begin
        rd_adr_o <= rd_adr_o + 1'b1;
      end
    end
  end

  // Valid lines up with the registered read data of the storage
  always_ff @(posedge clk_i or posedge a_rst_i) begin
    if (a_rst_i) begin
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= rd_ram_o;
    end
  end

  // --------------------------------------------------
  // Error strobes
  // --------------------------------------------------

  // Overflow: write strobe met a full FIFO
  // Underflow: read strobe met an empty FIFO
  always_ff @(posedge clk_i or posedge a_rst_i) begin
    if (a_rst_i) begin
      err_o <= '0;
    end else begin
      err_o.overflow  <= wr_en_i & flags_i.full;
      err_o.underflow <= rd_en_i & flags_i.empty;
    end
  end

endmodule

//--- verilog/sfifo_pkg.sv
/* Shared sizes, thresholds and types of the 16-entry synchronous FIFO.
   Imported by wildcard into every FIFO module and the testbench. */

package sfifo_pkg;

  // --------------------------------------------------
  // Storage geometry
  // --------------------------------------------------

  // Number of words the FIFO can hold
  localparam int unsigned FIFO_DEPTH = 16;

  // Address width of the storage array
  localparam int unsigned ADDR_W = $clog2(FIFO_DEPTH);

  // One extra bit so a count of FIFO_DEPTH fits
  localparam int unsigned CNT_W = ADDR_W + 1;

  // --------------------------------------------------
  // Programmable flag thresholds
  // --------------------------------------------------

  // prog_full sets at or above assert, clears at or below negate
  localparam int unsigned PROG_FULL_ASSERT = 12;
  localparam int unsigned PROG_FULL_NEGATE = 10;

  // prog_empty sets at or below assert, clears at or above negate
  localparam int unsigned PROG_EMPTY_ASSERT = 2;
  localparam int unsigned PROG_EMPTY_NEGATE = 4;

  // --------------------------------------------------
  // Types
  // --------------------------------------------------

  // Stored word, 24 data bits plus an 8-bit tag
  typedef struct packed {
    logic [23:0] data;
    logic [7:0]  tag;
  } sfifo_word_t;

  typedef logic [ADDR_W-1:0] sfifo_addr_t;

  typedef logic [CNT_W-1:0] sfifo_count_t;

  // Status flags, all registered in the status unit
  typedef struct packed {
    logic empty;
    logic almost_empty;
    logic prog_empty;
    logic almost_full;
    logic prog_full;
    logic full;
  } sfifo_flags_t;

  // Error strobes, one cycle wide
  typedef struct packed {
    logic overflow;
    logic underflow;
  } sfifo_err_t;

  // Flag state of an empty FIFO, used at reset
  localparam sfifo_flags_t FLAGS_RST = '{
    empty:        1'b1,
    almost_empty: 1'b1,
    prog_empty:   1'b1,
    default:      1'b0
  };

endpackage

//--- verilog/sfifo_ram.sv
/* FIFO storage: 16-word simple dual-port array with a registered read port,
   shaped for block RAM inference. */
`timescale 1ns/10ps

module sfifo_ram
  import sfifo_pkg::*;
(
  input  logic        clk_i,
  input  logic        wr_en_i,
  input  sfifo_addr_t wr_adr_i,
  input  sfifo_word_t wr_data_i,
  input  logic        rd_en_i,
  input  sfifo_addr_t rd_adr_i,
  output sfifo_word_t rd_data_o
);

  // Word storage, no reset
  sfifo_word_t mem [FIFO_DEPTH];

  // --------------------------------------------------
  // Write port
  // --------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem[wr_adr_i] <= wr_data_i;
    end
  end

  // --------------------------------------------------
  // Read port
  // --------------------------------------------------

  // Output register holds the last word when no read is accepted
  // A same-cycle write to the read address returns the old word
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_o <= mem[rd_adr_i];
    end
  end

endmodule

//--- verilog/sfifo_status.sv
/* FIFO status unit: keeps the occupancy count and registers every status
   flag from the next count, with hysteresis on the programmable flags. */
`timescale 1ns/10ps

module sfifo_status
  import sfifo_pkg::*;
(
  input  logic         clk_i,
  input  logic         a_rst_i,
  input  logic         wr_ram_i,
  input  logic         rd_ram_i,
  output sfifo_flags_t flags_o,
  output sfifo_count_t count_o
);

  // Count values the flags compare against
  localparam sfifo_count_t CNT_FULL   = sfifo_count_t'(FIFO_DEPTH);
  localparam sfifo_count_t CNT_AFULL  = sfifo_count_t'(FIFO_DEPTH - 1);
  localparam sfifo_count_t CNT_PF_SET = sfifo_count_t'(PROG_FULL_ASSERT);
  localparam sfifo_count_t CNT_PF_CLR = sfifo_count_t'(PROG_FULL_NEGATE);
  localparam sfifo_count_t CNT_PE_SET = sfifo_count_t'(PROG_EMPTY_ASSERT);
  localparam sfifo_count_t CNT_PE_CLR = sfifo_count_t'(PROG_EMPTY_NEGATE);

  // Occupancy after the current edge
  sfifo_count_t count_nxt;
  // Flags derived from count_nxt
  sfifo_flags_t flags_nxt;

  // --------------------------------------------------
  // Next occupancy
  // --------------------------------------------------

  always_comb begin
    case ({wr_ram_i, rd_ram_i})
      // Write alone
      2'b10:   count_nxt = count_o + 1'b1;
      // Read alone
      2'b01:   count_nxt = count_o - 1'b1;
      // Both or neither leave the count as is
      default: count_nxt = count_o;
    endcase
  end

  // --------------------------------------------------
  // Next flags
  // --------------------------------------------------

  always_comb begin
    flags_nxt.empty        = (count_nxt == '0);
    flags_nxt.almost_empty = (count_nxt <= sfifo_count_t'(1));
    flags_nxt.almost_full  = (count_nxt >= CNT_AFULL);
    flags_nxt.full         = (count_nxt == CNT_FULL);

    // prog_full holds its value between the two thresholds
    if (count_nxt >= CNT_PF_SET) begin
      flags_nxt.prog_full = 1'b1;
    end else if (count_nxt <= CNT_PF_CLR) begin
      flags_nxt.prog_full = 1'b0;
    end else begin
      flags_nxt.prog_full = flags_o.prog_full;
    end

    // prog_empty likewise, mirrored toward the empty end
    if (count_nxt <= CNT_PE_SET) begin
      flags_nxt.prog_empty = 1'b1;
    end else if (count_nxt >= CNT_PE_CLR) begin
      flags_nxt.prog_empty = 1'b0;
    end else begin
      flags_nxt.prog_empty = flags_o.prog_empty;
    end
  end

  // --------------------------------------------------
  // Registers
  // --------------------------------------------------

  // Count and flags move on the same edge
  always_ff @(posedge clk_i or posedge a_rst_i) begin
    if (a_rst_i) begin
      count_o <= '0;
      flags_o <= FLAGS_RST;
    end else begin
      count_o <= count_nxt;
      flags_o <= flags_nxt;
    end
  end

endmodule

//--- verilog/sfifo_top.sv
/* Top level of the synchronous FIFO, standard read mode.
   Connects the controller, the status unit and the storage array. */
`timescale 1ns/10ps

module sfifo_top
  import sfifo_pkg::*;
(
  input  logic         clk_i,
  input  logic         a_rst_i,
  // Write side
  input  logic         wr_en_i,
  input  sfifo_word_t  wr_data_i,
  output logic         wr_ack_o,
  // Read side
  input  logic         rd_en_i,
  output logic         rd_valid_o,
  output sfifo_word_t  rd_data_o,
  // Status
  output sfifo_flags_t flags_o,
  output sfifo_count_t count_o,
  output sfifo_err_t   err_o
);

  // Accepted write and read strobes
  logic        wr_ram;
  logic        rd_ram;
  // Storage addresses from the controller
  sfifo_addr_t wr_adr;
  sfifo_addr_t rd_adr;

  // --------------------------------------------------
  // Controller
  // --------------------------------------------------

  // Qualifies strobes with the registered status flags
  sfifo_ctl u_ctl (
    .clk_i      (clk_i),
    .a_rst_i    (a_rst_i),
    .wr_en_i    (wr_en_i),
    .rd_en_i    (rd_en_i),
    .flags_i    (flags_o),
    .wr_ram_o   (wr_ram),
    .rd_ram_o   (rd_ram),
    .wr_adr_o   (wr_adr),
    .rd_adr_o   (rd_adr),
    .wr_ack_o   (wr_ack_o),
    .rd_valid_o (rd_valid_o),
    .err_o      (err_o)
  );

  // --------------------------------------------------
  // Status unit
  // --------------------------------------------------

  sfifo_status u_status (
    .clk_i    (clk_i),
    .a_rst_i  (a_rst_i),
    .wr_ram_i (wr_ram),
    .rd_ram_i (rd_ram),
    .flags_o  (flags_o),
    .count_o  (count_o)
  );

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------

  // Read data arrives together with rd_valid_o
  sfifo_ram u_ram (
    .clk_i     (clk_i),
    .wr_en_i   (wr_ram),
    .wr_adr_i  (wr_adr),
    .wr_data_i (wr_data_i),
    .rd_en_i   (rd_ram),
    .rd_adr_i  (rd_adr),
    .rd_data_o (rd_data_o)
  );

endmodule
